//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module tb_mem_stage -f sim.f -o tb_mem_stage || exit 1
out=$(./obj_dir/tb_mem_stage 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Test passed' && exit 0 || exit 1

//--- sim.f
verilog/core_pkg.sv
verilog/stage_pkg.sv
verilog/pipe_stage_reg.sv
verilog/data_mem_unit.sv
verilog/writeback_unit.sv
verilog/mem_stage_top.sv
tb/tb_mem_stage.sv

//--- tb/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage
    import core_pkg::*;
();

    localparam int tb_words   = 64;
    localparam int max_cycles = 4000;                   // About 2200 stimulus cycles plus margin.

    typedef struct packed {
        logic [31:0] pc_4;
        logic        rf_w_en;
        logic [4:0]  rf_w_addr;
        logic [31:0] alu_res;
        logic [31:0] store_data;
        logic [31:0] sys_arg;
        dm_op_e      dm_op;
        wb_sel_e     wb_sel;
        logic        syscall_en;
    } instr_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        en;
    logic        clear;
    instr_t      cur;
    logic        rf_w_en;
    logic [4:0]  rf_w_addr;
    logic [31:0] rf_w_data;
    logic        print_valid;
    logic [31:0] print_data;
    logic        halt;

    logic [31:0] lfsr = 32'd65617;
    logic [7:0]  ref_mem [256] = '{default: 8'h00};     // 64 words span bytes 0 to 255.
    logic [31:0] print_q [$];
    instr_t      m_ex = '0;
    instr_t      m_wb = '0;
    logic [31:0] m_load = '0;
    logic        m_halt = 1'b0;
    logic        exp_pv = 1'b0;
    logic        exp_we = 1'b0;
    logic [4:0]  exp_wa = '0;
    logic [31:0] exp_wd = '0;
    logic [31:0] exp_print;
    string       test_name = "reset";
    int          cycles = 0;
    int          writes_seen = 0;
    int          loads_seen = 0;
    int          prints_seen = 0;

    mem_stage_top #(
        .dm_words (tb_words)
    ) u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .clear         (clear),
        .pc_4_in       (cur.pc_4),
        .rf_w_en_in    (cur.rf_w_en),
        .rf_w_addr_in  (cur.rf_w_addr),
        .alu_res_in    (cur.alu_res),
        .store_data_in (cur.store_data),
        .sys_arg_in    (cur.sys_arg),
        .dm_op_in      (cur.dm_op),
        .wb_sel_in     (cur.wb_sel),
        .syscall_en_in (cur.syscall_en),
        .rf_w_en       (rf_w_en),
        .rf_w_addr     (rf_w_addr),
        .rf_w_data     (rf_w_data),
        .print_valid   (print_valid),
        .print_data    (print_data),
        .halt          (halt)
    );

    always #20 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        stop_with_failure($sformatf("FAILED %s %s: expected 0x%08h, actual 0x%08h",
                                    test_name, what, exp_v, act_v));
    endtask

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // True with odds of one in 2**bits.
    function automatic logic chance(input int bits);
        logic [31:0] r;
        r = take_bits(bits);
        return r == '0;
    endfunction

    function automatic logic [31:0] ref_load(input instr_t i);
        logic [7:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        a = i.alu_res[7:0];
        b = ref_mem[a];
        h = {ref_mem[{a[7:1], 1'b1}], ref_mem[{a[7:1], 1'b0}]};
        w = {ref_mem[{a[7:2], 2'd3}], ref_mem[{a[7:2], 2'd2}],
             ref_mem[{a[7:2], 2'd1}], ref_mem[{a[7:2], 2'd0}]};
        case (i.dm_op)
            dm_lb:   return {{24{b[7]}}, b};
            dm_lbu:  return {24'd0, b};
            dm_lh:   return {{16{h[15]}}, h};
            dm_lhu:  return {16'd0, h};
            dm_lw:   return w;
            default: return '0;
        endcase
    endfunction

    task automatic ref_store(input instr_t i);
        logic [7:0] a;
        a = i.alu_res[7:0];
        case (i.dm_op)
            dm_sb: begin
                ref_mem[a] = i.store_data[7:0];
            end
            dm_sh: begin
                ref_mem[{a[7:1], 1'b0}] = i.store_data[7:0];
                ref_mem[{a[7:1], 1'b1}] = i.store_data[15:8];
            end
            dm_sw: begin
                for (int k = 0; k < 4; k++) begin
                    ref_mem[{a[7:2], 2'(k)}] = i.store_data[8*k +: 8];
                end
            end
            default: begin
            end
        endcase
    endtask

    function automatic instr_t make_alu_link();
        instr_t      i;
        logic [31:0] r;
        i           = '0;
        r           = take_bits(5);
        i.rf_w_en   = 1'b1;
        i.rf_w_addr = chance(3) ? 5'd0 : r[4:0];       // Extra hits on $zero.
        i.pc_4      = take_bits(32) & 32'hffff_fffc;
        i.alu_res   = take_bits(32);
        i.wb_sel    = chance(1) ? wb_pc4 : wb_alu;
        return i;
    endfunction

    function automatic instr_t make_store(input logic [31:0] addr);
        instr_t      i;
        logic [31:0] r;
        i = '0;
        r = take_bits(2);
        case (r[1:0])
            2'd1:    i.dm_op = dm_sh;
            2'd2:    i.dm_op = dm_sw;
            default: i.dm_op = dm_sb;
        endcase
        i.alu_res    = addr;
        i.store_data = take_bits(32);
        i.pc_4       = take_bits(32);
        return i;
    endfunction

    function automatic instr_t make_load(input logic [31:0] addr);
        instr_t      i;
        logic [31:0] r;
        i = '0;
        r = take_bits(3);
        case (r[2:0])
            3'd0, 3'd5: i.dm_op = dm_lb;
            3'd1, 3'd6: i.dm_op = dm_lbu;
            3'd2, 3'd7: i.dm_op = dm_lh;
            3'd3:       i.dm_op = dm_lhu;
            default:    i.dm_op = dm_lw;
        endcase
        r           = take_bits(5);
        i.rf_w_en   = 1'b1;
        i.rf_w_addr = r[4:0];
        i.alu_res   = addr;
        i.wb_sel    = wb_mem;
        i.pc_4      = take_bits(32);
        return i;
    endfunction

    function automatic instr_t make_syscall(input logic [31:0] code);
        instr_t i;
        i            = '0;
        i.syscall_en = 1'b1;
        i.sys_arg    = code;
        i.store_data = take_bits(32);                   // Value to print.
        i.pc_4       = take_bits(32);
        return i;
    endfunction

    // Any instruction but an exit.
    function automatic instr_t make_any();
        logic [31:0] r;
        r = take_bits(3);
        case (r[2:0])
            3'd3:    return make_store(take_bits(32));
            3'd4,
            3'd7:    return make_load(take_bits(32));
            3'd5:    return make_syscall(chance(1) ? sys_print : 32'd5);
            3'd6:    return '0;
            default: return make_alu_link();
        endcase
    endfunction

    task automatic drive(input instr_t i, input logic e, input logic c);
        @(posedge clk);
        en    <= e;
        clear <= c;
        cur   <= i;
    endtask

    // Reference pipeline, advanced by the same en and clear rules as the DUT.
    always @(posedge clk) begin
        if (!rst_n) begin
            m_ex   = '0;
            m_wb   = '0;
            m_load = '0;
            m_halt = 1'b0;
            exp_pv = 1'b0;
        end else begin
            if (en) begin
                exp_pv = m_wb.syscall_en && (m_wb.sys_arg == sys_print) && !m_halt;
                if (exp_pv) begin
                    print_q.push_back(m_wb.store_data);
                end
                if (m_wb.syscall_en && (m_wb.sys_arg == sys_exit)) begin
                    m_halt = 1'b1;
                end
                m_load = ref_load(m_ex);
                ref_store(m_ex);
                m_wb   = m_ex;
            end else begin
                exp_pv = 1'b0;
            end
            if (clear) begin
                m_ex = '0;
            end else if (en) begin
                m_ex = cur;
            end
        end
        exp_we = m_wb.rf_w_en && (m_wb.rf_w_addr != '0) && !m_halt;
        exp_wa = m_wb.rf_w_addr;
        case (m_wb.wb_sel)
            wb_mem:  exp_wd = m_load;
            wb_pc4:  exp_wd = m_wb.pc_4;
            default: exp_wd = m_wb.alu_res;
        endcase
    end

    // Checks sit mid-cycle, where DUT and reference are both settled.
    assert property (@(negedge clk) disable iff (!rst_n) rf_w_en == exp_we)
        else report_mismatch("rf_w_en", {31'd0, exp_we}, {31'd0, rf_w_en});
    assert property (@(negedge clk) disable iff (!rst_n) !exp_we || rf_w_addr == exp_wa)
        else report_mismatch("rf_w_addr", {27'd0, exp_wa}, {27'd0, rf_w_addr});
    assert property (@(negedge clk) disable iff (!rst_n) !exp_we || rf_w_data == exp_wd)
        else report_mismatch("rf_w_data", exp_wd, rf_w_data);
    assert property (@(negedge clk) disable iff (!rst_n) print_valid == exp_pv)
        else report_mismatch("print_valid", {31'd0, exp_pv}, {31'd0, print_valid});
    assert property (@(negedge clk) disable iff (!rst_n) halt == m_halt)
        else report_mismatch("halt", {31'd0, m_halt}, {31'd0, halt});
    assert property (@(negedge clk) disable iff (!rst_n) !(halt && (rf_w_en || print_valid)))
        else stop_with_failure("Register write or print seen while halted.");

    always @(negedge clk) begin
        if (rst_n && print_valid) begin
            assert (print_q.size() > 0)
                else stop_with_failure("print_valid rose with no print expected.");
            exp_print = print_q.pop_front();
            assert (print_data == exp_print)
                else report_mismatch("print_data", exp_print, print_data);
            prints_seen++;
        end
        if (rst_n && exp_we) begin
            writes_seen++;
            if (m_wb.wb_sel == wb_mem) begin
                loads_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            stop_with_failure("Timeout, the run went past the cycle limit.");
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] r;
        cur   = '0;
        en    = 1'b0;
        clear = 1'b0;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "reset_idle";
        for (int n = 0; n < 10; n++) begin
            drive('0, 1'b1, 1'b0);
        end

        test_name = "alu_link";
        for (int n = 0; n < 400; n++) begin
            drive(make_alu_link(), 1'b1, 1'b0);
        end

        // Each store is read back right away, from a random lane of the same word.
        test_name = "load_store";
        for (int n = 0; n < 300; n++) begin
            addr = take_bits(32);
            r    = take_bits(2);
            drive(make_store(addr), 1'b1, 1'b0);
            drive(make_load({addr[31:2], r[1:0]}), 1'b1, 1'b0);
            drive(make_load(take_bits(32)), 1'b1, 1'b0);
        end

        test_name = "stall_flush";
        for (int n = 0; n < 500; n++) begin
            drive(make_any(), !chance(2), chance(3));
        end
        for (int n = 0; n < 20; n++) begin
            addr = take_bits(32);
            drive(make_store(addr), 1'b1, 1'b0);
            drive('0, 1'b0, 1'b1);                      // Flushed before it can write.
            drive(make_load(addr), 1'b1, 1'b0);
        end

        test_name = "syscall_print";
        for (int n = 0; n < 200; n++) begin
            if (n % 3 == 0) begin
                drive(make_syscall(sys_print), !chance(2), 1'b0);
            end else begin
                drive(make_any(), !chance(2), 1'b0);
            end
        end

        test_name = "syscall_exit";
        drive(make_syscall(sys_exit), 1'b1, 1'b0);
        for (int n = 0; n < 80; n++) begin
            drive(n % 2 == 0 ? make_syscall(sys_print) : make_any(), 1'b1, 1'b0);
        end
        for (int n = 0; n < 5; n++) begin
            drive('0, 1'b1, 1'b0);
        end
        @(negedge clk);

        if (prints_seen > 0 && loads_seen > 0 && writes_seen > 0 && halt &&
            print_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            stop_with_failure("A print, load or halt was never seen as expected.");
        end
    end

endmodule

`default_nettype wire

//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int word_w     = 32;
    localparam int pc_w       = 32;
    localparam int reg_addr_w = 5;

    // Nine access kinds need a 4-bit code.
    typedef enum logic [3:0] {
        dm_none = 4'd0,
        dm_lb   = 4'd1,
        dm_lbu  = 4'd2,
        dm_lh   = 4'd3,
        dm_lhu  = 4'd4,
        dm_lw   = 4'd5,
        dm_sb   = 4'd6,
        dm_sh   = 4'd7,
        dm_sw   = 4'd8
    } dm_op_e;

    typedef enum logic [1:0] {
        wb_alu = 2'd0,                              // ALU result.
        wb_mem = 2'd1,                              // Load data.
        wb_pc4 = 2'd2                               // Link address.
    } wb_sel_e;

    // Syscall codes, as found in $v0.
    localparam logic [word_w-1:0] sys_print = 32'd1;
    localparam logic [word_w-1:0] sys_exit  = 32'd10;

endpackage

`default_nettype wire

//--- verilog/data_mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_unit
    import core_pkg::*;
#(
    parameter int dm_words = 256
) (
    input  logic              clk,
    input  logic              en,
    input  logic [word_w-1:0] addr,
    input  logic [word_w-1:0] store_data,
    input  dm_op_e            dm_op,
    output logic [word_w-1:0] load_data
);

    localparam int idx_w = $clog2(dm_words);

    logic [word_w-1:0] mem [dm_words] = '{default: '0};

    logic [idx_w-1:0]  idx;
    logic [word_w-1:0] rd_word;
    logic [7:0]        rd_byte;
    logic [15:0]       rd_half;
    logic [3:0]        wr_be;
    logic [word_w-1:0] wr_data;

    assign idx     = addr[idx_w+1:2];               // Wraps modulo depth.
    assign rd_word = mem[idx];

    // Little-endian lanes.
    always_comb begin
        case (addr[1:0])
            2'd0:    rd_byte = rd_word[7:0];
            2'd1:    rd_byte = rd_word[15:8];
            2'd2:    rd_byte = rd_word[23:16];
            default: rd_byte = rd_word[31:24];
        endcase
    end

    assign rd_half = addr[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (dm_op)
            dm_lb:   load_data = {{(word_w-8){rd_byte[7]}}, rd_byte};
            dm_lbu:  load_data = {{(word_w-8){1'b0}}, rd_byte};
            dm_lh:   load_data = {{(word_w-16){rd_half[15]}}, rd_half};
            dm_lhu:  load_data = {{(word_w-16){1'b0}}, rd_half};
            dm_lw:   load_data = rd_word;
            default: load_data = '0;
        endcase
    end

    // Value is replicated so each lane sees its own copy.
    always_comb begin
        wr_be   = 4'b0000;
        wr_data = store_data;
        case (dm_op)
            dm_sb: begin
                wr_be   = 4'b0001 << addr[1:0];
                wr_data = {4{store_data[7:0]}};
            end
            dm_sh: begin
                wr_be   = addr[1] ? 4'b1100 : 4'b0011;
                wr_data = {2{store_data[15:0]}};
            end
            dm_sw: begin
                wr_be   = 4'b1111;
            end
            default: begin
                wr_be   = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_be[b]) begin
                    mem[idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top
    import core_pkg::*;
    import stage_pkg::*;
#(
    parameter int dm_words = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic                  clear,
    input  logic [pc_w-1:0]       pc_4_in,
    input  logic                  rf_w_en_in,
    input  logic [reg_addr_w-1:0] rf_w_addr_in,
    input  logic [word_w-1:0]     alu_res_in,
    input  logic [word_w-1:0]     store_data_in,
    input  logic [word_w-1:0]     sys_arg_in,
    input  dm_op_e                dm_op_in,
    input  wb_sel_e               wb_sel_in,
    input  logic                  syscall_en_in,
    output logic                  rf_w_en,
    output logic [reg_addr_w-1:0] rf_w_addr,
    output logic [word_w-1:0]     rf_w_data,
    output logic                  print_valid,
    output logic [word_w-1:0]     print_data,
    output logic                  halt
);

    ex_mem_t           ex_mem_d;
    ex_mem_t           ex_mem_q;
    mem_wb_t           mem_wb_d;
    mem_wb_t           mem_wb_q;
    logic [word_w-1:0] load_data;

    assign ex_mem_d.pc_4       = pc_4_in;
    assign ex_mem_d.rf_w_en    = rf_w_en_in;
    assign ex_mem_d.rf_w_addr  = rf_w_addr_in;
    assign ex_mem_d.alu_res    = alu_res_in;
    assign ex_mem_d.store_data = store_data_in;
    assign ex_mem_d.sys_arg    = sys_arg_in;
    assign ex_mem_d.dm_op      = dm_op_in;
    assign ex_mem_d.wb_sel     = wb_sel_in;
    assign ex_mem_d.syscall_en = syscall_en_in;

    pipe_stage_reg #(
        .payload_t (ex_mem_t)
    ) u_ex_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .clear (clear),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    data_mem_unit #(
        .dm_words (dm_words)
    ) u_dmem (
        .clk        (clk),
        .en         (en),
        .addr       (ex_mem_q.alu_res),
        .store_data (ex_mem_q.store_data),
        .dm_op      (ex_mem_q.dm_op),
        .load_data  (load_data)
    );

    assign mem_wb_d.pc_4       = ex_mem_q.pc_4;
    assign mem_wb_d.rf_w_en    = ex_mem_q.rf_w_en;
    assign mem_wb_d.rf_w_addr  = ex_mem_q.rf_w_addr;
    assign mem_wb_d.alu_res    = ex_mem_q.alu_res;
    assign mem_wb_d.load_data  = load_data;
    assign mem_wb_d.store_data = ex_mem_q.store_data;
    assign mem_wb_d.sys_arg    = ex_mem_q.sys_arg;
    assign mem_wb_d.wb_sel     = ex_mem_q.wb_sel;
    assign mem_wb_d.syscall_en = ex_mem_q.syscall_en;

    // Flush only reaches EX/MEM.
    pipe_stage_reg #(
        .payload_t (mem_wb_t)
    ) u_mem_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .clear (1'b0),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    writeback_unit u_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .pc_4         (mem_wb_q.pc_4),
        .rf_w_en_in   (mem_wb_q.rf_w_en),
        .rf_w_addr_in (mem_wb_q.rf_w_addr),
        .alu_res      (mem_wb_q.alu_res),
        .load_data    (mem_wb_q.load_data),
        .sys_arg      (mem_wb_q.sys_arg),
        .print_arg    (mem_wb_q.store_data),
        .wb_sel       (mem_wb_q.wb_sel),
        .syscall_en   (mem_wb_q.syscall_en),
        .rf_w_en      (rf_w_en),
        .rf_w_addr    (rf_w_addr),
        .rf_w_data    (rf_w_data),
        .print_valid  (print_valid),
        .print_data   (print_data),
        .halt         (halt)
    );

endmodule

`default_nettype wire

//--- verilog/pipe_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     clear,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;                                // Flush wins over advance.
        end else if (en) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/stage_pkg.sv
`default_nettype none

package stage_pkg;

    import core_pkg::*;

    // All zeros is a bubble.
    typedef struct packed {
        logic [pc_w-1:0]       pc_4;
        logic                  rf_w_en;
        logic [reg_addr_w-1:0] rf_w_addr;
        logic [word_w-1:0]     alu_res;             // Also the memory address.
        logic [word_w-1:0]     store_data;          // Also the print argument.
        logic [word_w-1:0]     sys_arg;
        dm_op_e                dm_op;
        wb_sel_e               wb_sel;
        logic                  syscall_en;
    } ex_mem_t;

    typedef struct packed {
        logic [pc_w-1:0]       pc_4;
        logic                  rf_w_en;
        logic [reg_addr_w-1:0] rf_w_addr;
        logic [word_w-1:0]     alu_res;
        logic [word_w-1:0]     load_data;
        logic [word_w-1:0]     store_data;          // Carried on for syscall print.
        logic [word_w-1:0]     sys_arg;
        wb_sel_e               wb_sel;
        logic                  syscall_en;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- verilog/writeback_unit.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_unit
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic [pc_w-1:0]       pc_4,
    input  logic                  rf_w_en_in,
    input  logic [reg_addr_w-1:0] rf_w_addr_in,
    input  logic [word_w-1:0]     alu_res,
    input  logic [word_w-1:0]     load_data,
    input  logic [word_w-1:0]     sys_arg,
    input  logic [word_w-1:0]     print_arg,
    input  wb_sel_e               wb_sel,
    input  logic                  syscall_en,
    output logic                  rf_w_en,
    output logic [reg_addr_w-1:0] rf_w_addr,
    output logic [word_w-1:0]     rf_w_data,
    output logic                  print_valid,
    output logic [word_w-1:0]     print_data,
    output logic                  halt
);

    logic [word_w-1:0] wb_value;
    logic              is_print;
    logic              is_exit;

    always_comb begin
        case (wb_sel)
            wb_mem:  wb_value = load_data;
            wb_pc4:  wb_value = pc_4;
            default: wb_value = alu_res;
        endcase
    end

    // $zero is hardwired.
    assign rf_w_en   = rf_w_en_in && (rf_w_addr_in != '0) && !halt;
    assign rf_w_addr = halt ? '0 : rf_w_addr_in;
    assign rf_w_data = halt ? '0 : wb_value;

    assign is_print = syscall_en && (sys_arg == sys_print) && !halt;
    assign is_exit  = syscall_en && (sys_arg == sys_exit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            print_valid <= 1'b0;
            halt        <= 1'b0;
        end else if (en) begin
            print_valid <= is_print;                // One pulse per syscall.
            if (is_exit) begin
                halt <= 1'b1;                       // Sticky until reset.
            end
        end else begin
            print_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (en && is_print) begin
            print_data <= print_arg;
        end
    end

endmodule

`default_nettype wire
